// File: source/line_pkg.sv
/* Shared types and constants for the line drawing video design.
   Holds the 640x480 timing, framebuffer geometry and the fixed palette. */
`default_nettype none

package line_pkg;

    typedef logic signed [15:0] coord_t;  // screen and fb coordinates
    typedef logic [1:0]         cidx_t;   // colour index
    typedef logic [3:0]         chan_t;   // one colour channel
    typedef logic [13:0]        fb_addr_t;  // linear fb address

    // 640x480 at 60 Hz, pixels and lines
    localparam coord_t H_RES   = 640;
    localparam coord_t H_FP    = 16;
    localparam coord_t H_SYNC  = 96;
    localparam coord_t H_BP    = 48;
    localparam coord_t H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam coord_t V_RES   = 480;
    localparam coord_t V_FP    = 10;
    localparam coord_t V_SYNC  = 2;
    localparam coord_t V_BP    = 33;
    localparam coord_t V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    localparam coord_t FB_WIDTH  = 160;
    localparam coord_t FB_HEIGHT = 90;
    localparam coord_t FB_SCALE  = 4;  // power of two, used as a shift
    localparam int     FB_DEPTH  = int'(FB_WIDTH) * int'(FB_HEIGHT);  // 14400

    localparam coord_t LB_TOP    = 60;   // first letterbox row
    localparam coord_t LB_BOTTOM = 420;  // exclusive

    // 12-bit rgb per index
    localparam logic [11:0] PALETTE [4] = '{12'h000, 12'hf80, 12'h0cf, 12'hfff};

endpackage

`default_nettype wire

// File: source/fb_write_if.sv
/* Framebuffer write port between the line drawing side and the memory.
   The memory raises busy while the display owns its single port. */
`timescale 1ns/1ns
`default_nettype none

interface fb_write_if
    import line_pkg::*;
();

    logic   we;    // write this pixel
    coord_t x;     // fb column
    coord_t y;     // fb row
    cidx_t  cidx;  // colour, held for the whole line
    logic   busy;  // memory taken by scanout

    modport draw (output we, x, y, cidx, input busy);
    modport mem  (input we, x, y, cidx, output busy);

endinterface

`default_nettype wire

// File: source/display_timings.sv
/* 640x480 display timing generator. Gives the scan position, negative
   syncs, data enable and the frame and line strobes, all registered. */
`timescale 1ns/1ns
`default_nettype none

module display_timings
    import line_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst,
    output coord_t    sx,     // horizontal scan position
    output coord_t    sy,     // vertical scan position
    output logic      hsync,  // active low
    output logic      vsync,  // active low
    output logic      de,     // inside the 640x480 window
    output logic      frame,  // one cycle at 0,0
    output logic      line    // one cycle at the start of each row
);

    coord_t x_next;  // position after this clock
    coord_t y_next;
    logic   eol;     // last pixel of the row

    always_comb begin
        eol    = (sx == H_TOTAL - coord_t'(1));
        x_next = eol ? '0 : sx + coord_t'(1);
        y_next = sy;
        if (eol) begin
            y_next = (sy == V_TOTAL - coord_t'(1)) ? '0 : sy + coord_t'(1);  // wrap frame
        end
    end

    // outputs decoded from the next position, so they line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= H_TOTAL - coord_t'(1);  // next clock lands on 0,0
            sy    <= V_TOTAL - coord_t'(1);
            hsync <= 1'b1;  // idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= x_next;
            sy    <= y_next;
            hsync <= !(x_next >= H_RES + H_FP && x_next < H_RES + H_FP + H_SYNC);
            vsync <= !(y_next >= V_RES + V_FP && y_next < V_RES + V_FP + V_SYNC);
            de    <= (x_next < H_RES && y_next < V_RES);
            frame <= (x_next == '0 && y_next == '0);
            line  <= (x_next == '0);
        end
    end

    // counter wraps before the line total on every row
    sx_in_line: assert property (@(posedge clk_pix) disable iff (rst)
        sx < H_TOTAL)
        else $error("sx reached the line total");

endmodule

`default_nettype wire

// File: source/draw_line.sv
/* Bresenham line stepper. Walks from x0,y0 to x1,y1 and puts one pixel on
   the fb write port per cycle in which the memory is not busy. */
`timescale 1ns/1ns
`default_nettype none

module draw_line
    import line_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire logic   start,    // one cycle pulse
    input  wire coord_t x0,
    input  wire coord_t y0,
    input  wire coord_t x1,
    input  wire coord_t y1,
    fb_write_if.draw    fb,
    output logic        drawing,  // pixels still to write
    output logic        done      // one cycle after the last pixel
);

    typedef enum logic [1:0] {st_idle, st_init, st_draw, st_done} state_t;
    state_t state;

    coord_t x, y;          // pen position
    coord_t x_end, y_end;  // far endpoint
    coord_t dx, dy;        // |dx| and -|dy|
    coord_t err;           // bresenham error term
    coord_t e2;            // doubled error
    coord_t adx, ady;      // distances to the end, for init
    logic   right, down;   // step directions
    logic   move_x, move_y;
    logic   last;          // pen sits on the endpoint

    always_comb begin
        adx     = (x_end >= x) ? x_end - x : x - x_end;
        ady     = (y_end >= y) ? y_end - y : y - y_end;
        e2      = err <<< 1;
        move_x  = (e2 >= dy);
        move_y  = (e2 <= dx);
        last    = (x == x_end && y == y_end);
        drawing = (state == st_draw);
        done    = (state == st_done);
        fb.we   = drawing && !fb.busy;  // only write on a free port
        fb.x    = x;
        fb.y    = y;
    end

    always_ff @(posedge clk_pix) begin
        case (state)
            st_idle: begin
                if (start) begin
                    x     <= x0;
                    y     <= y0;
                    x_end <= x1;
                    y_end <= y1;
                    state <= st_init;
                end
            end
            st_init: begin  // deltas from the latched endpoints
                dx    <= adx;
                dy    <= -ady;
                err   <= adx - ady;  // dx + dy
                right <= (x_end > x);
                down  <= (y_end > y);
                state <= st_draw;
            end
            st_draw: begin
                if (!fb.busy) begin  // hold everything while stalled
                    if (last) begin
                        state <= st_done;
                    end else begin
                        if (move_x) begin
                            x <= right ? x + coord_t'(1) : x - coord_t'(1);
                        end
                        if (move_y) begin
                            y <= down ? y + coord_t'(1) : y - coord_t'(1);
                        end
                        err <= err + (move_x ? dy : '0) + (move_y ? dx : '0);
                    end
                end
            end
            default: state <= st_idle;  // done lasts one cycle
        endcase
        if (rst) begin
            state <= st_idle;
        end
    end

    // memory busy means no write this cycle
    no_write_busy: assert property (@(posedge clk_pix) disable iff (rst)
        fb.busy |-> !fb.we)
        else $error("write issued while framebuffer busy");

endmodule

`default_nettype wire

// File: source/draw_control.sv
/* Line request control. Latches one request, waits for the next frame,
   starts the stepper and reports completion to the host. */
`timescale 1ns/1ns
`default_nettype none

module draw_control
    import line_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire logic   req,        // held by host until active
    input  wire coord_t x0,
    input  wire coord_t y0,
    input  wire coord_t x1,
    input  wire coord_t y1,
    input  wire cidx_t  cidx,
    input  wire logic   frame,      // start of frame strobe
    input  wire logic   drawing,    // stepper busy walking
    input  wire logic   step_done,  // stepper finished
    output logic        active,     // request taken, line not done
    output logic        done,
    output logic        start,      // pulse to the stepper
    output coord_t      line_x0,    // latched request
    output coord_t      line_y0,
    output coord_t      line_x1,
    output coord_t      line_y1,
    fb_write_if.draw    fb          // colour only
);

    typedef enum logic [1:0] {st_idle, st_wait_frame, st_draw} state_t;
    state_t state;

    always_ff @(posedge clk_pix) begin
        start <= 1'b0;
        case (state)
            st_idle: begin
                if (req) begin
                    line_x0 <= x0;
                    line_y0 <= y0;
                    line_x1 <= x1;
                    line_y1 <= y1;
                    fb.cidx <= cidx;  // held until the next request
                    state   <= st_wait_frame;
                end
            end
            st_wait_frame: begin
                if (frame) begin
                    start <= 1'b1;  // cycle after the frame strobe
                    state <= st_draw;
                end
            end
            st_draw: begin
                if (step_done) begin
                    state <= st_idle;
                end
            end
            default: state <= st_idle;
        endcase
        if (rst) begin
            state <= st_idle;
            start <= 1'b0;
        end
    end

    always_comb begin
        active = (state != st_idle);
        done   = step_done;
    end

    // stepper only runs on behalf of an accepted request
    draw_owned: assert property (@(posedge clk_pix) disable iff (rst)
        !active |-> !drawing)
        else $error("stepper drawing without a request");

endmodule

`default_nettype wire

// File: source/framebuffer.sv
/* Single-port 160x90 index framebuffer. The display scan reads it inside
   the letterbox and line writes use the port at all other times. */
`timescale 1ns/1ns
`default_nettype none

module framebuffer
    import line_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire coord_t sx,         // scan position
    input  wire coord_t sy,
    input  wire logic   hsync,
    input  wire logic   vsync,
    input  wire logic   de,
    fb_write_if.mem     fb,
    output logic        hsync_out,  // delayed to match colour
    output logic        vsync_out,
    output logic        de_out,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue
);

    cidx_t       mem [FB_DEPTH];  // one index per fb pixel
    logic        scan;            // display owns the port
    coord_t      rd_row;          // fb row under the beam
    coord_t      rd_col;
    coord_t      rd_lin;          // linear read position
    coord_t      wr_lin;          // linear write position
    fb_addr_t    addr;            // the single port address
    logic [11:0] colour;          // registered palette output

    initial begin  // image starts black
        for (int i = 0; i < FB_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        scan    = de && sy >= LB_TOP && sy < LB_BOTTOM;
        rd_row  = (sy - LB_TOP) >>> $clog2(FB_SCALE);  // 4 display rows per fb row
        rd_col  = sx >>> $clog2(FB_SCALE);
        rd_lin  = rd_row * FB_WIDTH + rd_col;
        wr_lin  = fb.y * FB_WIDTH + fb.x;
        addr    = fb_addr_t'(scan ? rd_lin : wr_lin);
        fb.busy = scan;  // stall writes during scanout
    end

    always_ff @(posedge clk_pix) begin
        if (fb.we && !scan) begin
            mem[addr] <= fb.cidx;
        end
    end

    // read and palette lookup share one register stage
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            colour    <= '0;
            hsync_out <= 1'b1;  // idle high
            vsync_out <= 1'b1;
            de_out    <= 1'b0;
        end else begin
            colour    <= scan ? PALETTE[mem[addr]] : '0;  // black outside letterbox
            hsync_out <= hsync;
            vsync_out <= vsync;
            de_out    <= de;
        end
    end

    always_comb begin
        red   = colour[11:8];
        green = colour[7:4];
        blue  = colour[3:0];
    end

    // stepper coordinates must land inside the 160x90 array
    wr_in_range: assert property (@(posedge clk_pix) disable iff (rst)
        fb.we |-> (int'(wr_lin) >= 0 && int'(wr_lin) < FB_DEPTH))
        else $error("framebuffer write address out of range");

endmodule

`default_nettype wire

// File: source/line_top.sv
/* Top level of the line drawing video design. Connects timing, request
   control, the Bresenham stepper and the framebuffer on clk_pix. */
`timescale 1ns/1ns
`default_nettype none

module line_top
    import line_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire logic   req,     // line request
    input  wire coord_t x0,      // endpoints in fb coordinates
    input  wire coord_t y0,
    input  wire coord_t x1,
    input  wire coord_t y1,
    input  wire cidx_t  cidx,    // line colour
    output logic        active,  // request accepted and in progress
    output logic        done,    // line finished
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue
);

    coord_t sx, sy;              // scan position
    logic   tim_hsync, tim_vsync, tim_de;
    logic   frame;
    coord_t line_x0, line_y0;    // latched request
    coord_t line_x1, line_y1;
    logic   draw_start, drawing, draw_done;

    fb_write_if fb ();

    display_timings timings_inst (
        .clk_pix, .rst,
        .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .frame, .line()
    );

    draw_control control_inst (
        .clk_pix, .rst,
        .req, .x0, .y0, .x1, .y1, .cidx,
        .frame, .drawing, .step_done(draw_done),
        .active, .done, .start(draw_start),
        .line_x0, .line_y0, .line_x1, .line_y1,
        .fb(fb.draw)
    );

    draw_line line_inst (
        .clk_pix, .rst,
        .start(draw_start),
        .x0(line_x0), .y0(line_y0), .x1(line_x1), .y1(line_y1),
        .fb(fb.draw),
        .drawing, .done(draw_done)
    );

    framebuffer fb_inst (
        .clk_pix, .rst,
        .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .fb(fb.mem),
        .hsync_out(hsync), .vsync_out(vsync), .de_out(de),
        .red, .green, .blue
    );

endmodule

`default_nettype wire

// File: testbench/tb_line_top.sv
/* Testbench for line_top. Sends random line requests, keeps a Bresenham model
   of the 160x90 image and checks each displayed frame and the sync timing. */
`timescale 1ns/1ns
`default_nettype none

module tb_line_top
    import line_pkg::*;
();

    localparam int NUM_REQ   = 6;
    localparam int FRAME_CYC = 800 * 525;  // 420000 clocks per frame
    localparam int TIMEOUT   = (2 + 3 * NUM_REQ) * FRAME_CYC;  // about 2 frames per line + slack

    logic   clk_pix;
    logic   rst;
    logic   req;
    coord_t x0, y0, x1, y1;
    cidx_t  cidx;
    logic   active, done, hsync, vsync, de;
    chan_t  red, green, blue;

    logic [11:0] pal [4] = '{12'h000, 12'hf80, 12'h0cf, 12'hfff};  // black orange cyan white
    logic [1:0]  model [160][90];  // expected index per fb pixel
    logic [31:0] lcg_state = 32'hc2637818;
    int          cycles;
    int          done_count;  // done pulses seen so far

    line_top dut (
        .clk_pix, .rst, .req, .x0, .y0, .x1, .y1, .cidx,
        .active, .done, .hsync, .vsync, .de, .red, .green, .blue
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;  // 25 MHz
    end

    task automatic report_mismatch(string name, int got, int exp);
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, what);
    endtask

    // one clock, then sample and drive 5 ns after the edge
    task automatic tick();
        @(posedge clk_pix);
        #5;
        cycles++;
        if (done) begin
            done_count++;
        end
        assert (cycles < TIMEOUT) else report_failure("timeout, the DUT stopped making progress");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference line walk, both endpoints plotted
    task automatic model_line(int ax, int ay, int bx, int by, int c);
        int dx, dy, err, e2, px, py, stx, sty;
        dx  = (bx > ax) ? bx - ax : ax - bx;
        dy  = (by > ay) ? ay - by : by - ay;  // minus |dy|
        stx = (bx > ax) ? 1 : -1;
        sty = (by > ay) ? 1 : -1;
        err = dx + dy;
        px  = ax;
        py  = ay;
        forever begin
            model[px][py] = c[1:0];
            if (px == bx && py == by) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                px  += stx;
            end
            if (e2 <= dx) begin
                err += dx;
                py  += sty;
            end
        end
    endtask

    function automatic int expect_rgb(int px, int py);
        if (py < 60 || py >= 420) begin
            return 0;  // letterbox bars
        end
        return int'(pal[model[px / 4][(py - 60) / 4]]);
    endfunction

    task automatic check_reset_outputs();
        assert (!active && !done) else report_failure("active or done high around reset");
        assert (!de) else report_mismatch("de", int'(de), 0);
        assert (hsync && vsync) else report_failure("syncs not at their idle level");
        assert ({red, green, blue} == 12'h000)
            else report_mismatch("rgb", int'({red, green, blue}), 0);
    endtask

    // one frame from vsync fall to vsync fall, pixels counted by de
    task automatic check_frame();
        int   total, npix, hs_run, hs_pulses, vs_low, exp, got;
        logic prev_vs;
        logic first;
        total     = 0;
        npix      = 0;
        hs_run    = 0;
        hs_pulses = 0;
        vs_low    = 0;
        prev_vs   = 1'b1;
        first     = 1'b1;
        while (!vsync) begin
            tick();
        end
        while (vsync) begin
            tick();
        end
        while (first || !(prev_vs && !vsync)) begin
            assert (!active && !done) else report_failure("line activity with no request pending");
            total++;
            if (!vsync) begin
                vs_low++;
            end
            if (!hsync) begin
                hs_run++;
            end else if (hs_run > 0) begin  // end of a sync pulse
                assert (hs_run == 96) else report_mismatch("hsync low length", hs_run, 96);
                hs_pulses++;
                hs_run = 0;
            end
            got = int'({red, green, blue});
            if (de) begin
                exp = expect_rgb(npix % 640, npix / 640);
                assert (got == exp)
                    else report_mismatch($sformatf("rgb at %0d,%0d", npix % 640, npix / 640),
                                         got, exp);
                npix++;
            end else begin
                assert (got == 0) else report_mismatch("rgb with de low", got, 0);
            end
            prev_vs = vsync;
            first   = 1'b0;
            tick();
        end
        assert (npix == 640 * 480) else report_mismatch("de high cycles", npix, 640 * 480);
        assert (hs_pulses == 525) else report_mismatch("hsync pulses", hs_pulses, 525);
        assert (vs_low == 2 * 800) else report_mismatch("vsync low cycles", vs_low, 1600);
        assert (total == FRAME_CYC) else report_mismatch("frame length", total, FRAME_CYC);
    endtask

    task automatic draw_request(int ax, int ay, int bx, int by, int c);
        int start_count;
        start_count = done_count;
        assert (!active) else report_failure("active high before the request");
        req  = 1'b1;
        x0   = coord_t'(ax);
        y0   = coord_t'(ay);
        x1   = coord_t'(bx);
        y1   = coord_t'(by);
        cidx = cidx_t'(c);
        tick();
        while (!active) begin
            tick();
        end
        cidx = cidx_t'(c + 1);  // a second acceptance would pick up this colour
        repeat (3) begin  // req still up, must not queue another line
            tick();
            assert (active) else report_failure("active dropped while req was held");
        end
        req = 1'b0;
        x0  = '0;  // stepper must use the latched endpoints
        y0  = '0;
        while (done_count == start_count) begin
            assert (active) else report_failure("active dropped before the done pulse");
            tick();
        end
        tick();
        assert (!done) else report_failure("done lasted more than one cycle");
        assert (!active) else report_failure("active still high after done");
    endtask

    initial begin
        int ax, ay, bx, by, c;
        int prev_ax, prev_ay, prev_c;
        rst        = 1'b1;
        req        = 1'b0;
        x0         = '0;
        y0         = '0;
        x1         = '0;
        y1         = '0;
        cidx       = '0;
        cycles     = 0;
        done_count = 0;
        prev_ax    = 0;
        prev_ay    = 0;
        prev_c     = 0;
        for (int i = 0; i < 160; i++) begin
            for (int j = 0; j < 90; j++) begin
                model[i][j] = 2'd0;
            end
        end
        repeat (5) begin
            tick();
            check_reset_outputs();
        end
        rst = 1'b0;
        tick();
        check_reset_outputs();
        check_frame();  // blank image before any line
        for (int i = 0; i < NUM_REQ; i++) begin
            if (i % 2 == 1) begin  // shares a start pixel, new colour overwrites it
                ax = prev_ax;
                ay = prev_ay;
                c  = (prev_c + 1) % 4;
            end else begin
                ax = int'((next_rand() >> 8) % 160);
                ay = int'((next_rand() >> 8) % 90);
                c  = int'((next_rand() >> 8) % 4);
            end
            bx = int'((next_rand() >> 8) % 160);
            by = int'((next_rand() >> 8) % 90);
            draw_request(ax, ay, bx, by, c);
            model_line(ax, ay, bx, by, c);
            check_frame();
            prev_ax = ax;
            prev_ay = ay;
            prev_c  = c;
        end
        assert (done_count == NUM_REQ) else report_mismatch("done pulses", done_count, NUM_REQ);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/line_pkg.sv
source/fb_write_if.sv
source/display_timings.sv
source/draw_line.sv
source/draw_control.sv
source/framebuffer.sv
source/line_top.sv
testbench/tb_line_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the line_top testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_line_top -f list.f -o sim_line

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/sim_line > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
